// ==== Bender.yml ====
package:
  name: sliding_detector

sources:
  - target: rtl
    files:
      - src/detector_pkg.sv
      - src/residual_window.sv
      - src/fp_checker.sv
      - src/sliding_detector_single_slice.sv
      - src/bit_corrector.sv
      - src/sliding_detector_top.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/detector_tb.sv

// ==== bench/detector_ref.svh ====
`ifndef DETECTOR_REF_SVH
`define DETECTOR_REF_SVH

typedef struct packed {
    logic [FLAG_BITWIDTH-1:0] error_flag;
    energy_t                  mmse_val;
    logic [SEQ_LENGTH-1:0]    corrected_bits;
    int                       stamp;            // drive cycle of the completing strobe
} exp_t;

// residual change at position i that a flip of pattern pidx leaves through the channel
function automatic int event_response(
    input int                    pidx,
    input logic [SEQ_LENGTH-1:0] bits,
    input int                    i,
    input channel_t              ch
);
    int sum;
    int d;
    sum = 0;
    for (int j = 0; j < FLIP_PATTERN_DEPTH; j++) begin
        if (!FLIP_PATTERNS[pidx][j]) begin
            d = 0;
        end else if (bits[j]) begin
            d = -2;  // a one moves down to minus one
        end else begin
            d = 2;
        end
        sum += d * int'(ch[i - j + FLIP_PATTERN_DEPTH - 1]);
    end
    return sum;
endfunction

// pidx below zero means the unflipped hypothesis
function automatic int window_energy(
    input int                         pidx,
    input logic [SEQ_LENGTH-1:0]      bits,
    input residual_t [SEQ_LENGTH-1:0] res,
    input channel_t                   ch
);
    int sum;
    int adj;
    sum = 0;
    for (int i = 0; i < SEQ_LENGTH; i++) begin
        adj = int'(res[i]);
        if (pidx >= 0) begin
            adj += event_response(pidx, bits, i, ch);
        end
        sum += adj * adj;
    end
    if (sum > int'(ENER_MAX)) begin
        sum = int'(ENER_MAX);  // saturate
    end
    return sum;
endfunction

function automatic exp_t ref_window(
    input logic [SEQ_LENGTH-1:0]      bits,
    input residual_t [SEQ_LENGTH-1:0] res,
    input channel_t                   ch
);
    exp_t e;
    int   ener [NUM_FLIP_PATTERNS+1];
    int   best;
    for (int k = 0; k <= NUM_FLIP_PATTERNS; k++) begin
        ener[k] = window_energy(k - 1, bits, res, ch);
    end
    best = 0;
    for (int k = 1; k <= NUM_FLIP_PATTERNS; k++) begin
        if (ener[k] < ener[best]) begin
            best = k;  // strict compare keeps ties on the lower index
        end
    end
    e.error_flag = FLAG_BITWIDTH'(best);
    e.mmse_val   = energy_t'(ener[best]);
    if (best == 0) begin
        e.corrected_bits = bits;
    end else begin
        e.corrected_bits = bits ^ FLIP_PATTERNS[best-1];
    end
    e.stamp = 0;
    return e;
endfunction

`endif

// ==== bench/detector_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module detector_tb
    import detector_pkg::*;
();

`include "detector_ref.svh"

    localparam int RESET_CYCLES   = 8;
    localparam int N_CLEAN        = 30;
    localparam int N_EVENT_GROUPS = 16;
    localparam int N_TIE_GROUPS   = 12;
    localparam int N_RANDOM       = 300;
    localparam int MAX_GAP        = 3;
    localparam int DRAIN_CYCLES   = 6;
    localparam int STIM_CYCLES    = 2 * (RESET_CYCLES + DRAIN_CYCLES) + N_CLEAN + DRAIN_CYCLES
                                  + 3 * (N_EVENT_GROUPS + N_TIE_GROUPS)
                                  + (MAX_GAP + 1) * N_RANDOM + 20;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

    logic                      clk;
    logic                      rst_n;
    logic                      sample_valid;
    logic                      sample_bit;
    residual_t                 sample_residual;
    channel_t                  channel;
    logic                      out_valid;
    logic [SEQ_LENGTH-1:0]     corrected_bits;
    logic [FLAG_BITWIDTH-1:0]  error_flag;
    energy_t                   mmse_val;
    logic [COUNT_BITWIDTH-1:0] correction_count;

    exp_t                       exp_q [$];
    exp_t                       last_exp;
    logic [SEQ_LENGTH-1:0]      shadow_bits;
    residual_t [SEQ_LENGTH-1:0] shadow_res;
    int                         shadow_fill;
    logic [COUNT_BITWIDTH-1:0]  exp_count;
    int cyc             = 0;
    int n_windows       = 0;
    int n_outputs       = 0;
    int mismatch_errors = 0;
    int protocol_errors = 0;

    sliding_detector_top dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .sample_valid     (sample_valid),
        .sample_bit       (sample_bit),
        .sample_residual  (sample_residual),
        .channel          (channel),
        .out_valid        (out_valid),
        .corrected_bits   (corrected_bits),
        .error_flag       (error_flag),
        .mmse_val         (mmse_val),
        .correction_count (correction_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic apply_reset(input int n);
        rst_n       = 1'b0;
        shadow_fill = 0;  // window count restarts
        idle(n);
        rst_n = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            mismatch_errors++;
            $display("Mismatch %s: expected 0x%0h got 0x%0h", name, want, got);
        end
    endtask

    task automatic send_sample(input logic b, input residual_t r);
        sample_valid    = 1'b1;
        sample_bit      = b;
        sample_residual = r;
        shadow_bits     = {b, shadow_bits[SEQ_LENGTH-1:1]};
        shadow_res      = {r, shadow_res[SEQ_LENGTH-1:1]};
        if (shadow_fill < SEQ_LENGTH) begin
            shadow_fill++;
        end
        if (shadow_fill == SEQ_LENGTH) begin
            last_exp       = ref_window(shadow_bits, shadow_res, channel);
            last_exp.stamp = cyc;
            exp_q.push_back(last_exp);
            n_windows++;
        end
        next_cycle();
        sample_valid = 1'b0;
    endtask

    // three strobes whose residuals are an error event, or half of one for a tie
    task automatic inject_group(input int pidx, input bit halve);
        logic [SEQ_LENGTH-1:0] b;
        int                    resp;
        b = SEQ_LENGTH'($urandom());
        for (int i = 0; i < SEQ_LENGTH; i++) begin
            resp = event_response(pidx, b, i, channel);
            send_sample(b[i], residual_t'(halve ? -resp / 2 : -resp));
        end
        if (!halve) begin
            assert (last_exp.error_flag == FLAG_BITWIDTH'(pidx + 1) && last_exp.mmse_val == 0)
            else begin
                protocol_errors++;
                $display("injected event for pattern %0d is not the cheapest hypothesis", pidx);
            end
        end
    endtask

    task automatic report_counts(input int timeouts);
        $display("errors: mismatch %0d, protocol %0d, timeout %0d",
                 mismatch_errors, protocol_errors, timeouts);
    endtask

    always @(negedge clk) begin : compare_outputs
        exp_t e;
        if (rst_n !== 1'b1) begin
            exp_count = '0;
        end else if (out_valid === 1'b1) begin
            n_outputs++;
            assert (exp_q.size() > 0) else begin
                protocol_errors++;
                $display("out_valid seen at cycle %0d with no window pending", cyc);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                if (e.error_flag != '0) begin
                    exp_count++;
                end
                check_value("error_flag", 32'(error_flag), 32'(e.error_flag));
                check_value("mmse_val", 32'(mmse_val), 32'(e.mmse_val));
                check_value("corrected_bits", 32'(corrected_bits), 32'(e.corrected_bits));
                check_value("correction_count", 32'(correction_count), 32'(exp_count));
                check_value("out_valid latency", cyc - e.stamp, 2);
            end
        end
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_counts(1);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hddf3));
        rst_n           = 1'b0;
        sample_valid    = 1'b0;
        sample_bit      = 1'b0;
        sample_residual = '0;
        shadow_bits     = '0;
        shadow_res      = '0;
        shadow_fill     = 0;
        channel[0]      = 8'sd2;
        channel[1]      = -8'sd5;
        channel[2]      = 8'sd24;  // dominant main tap keeps events distinct
        channel[3]      = 8'sd7;
        channel[4]      = -8'sd3;
        apply_reset(RESET_CYCLES);

        repeat (N_CLEAN) send_sample(1'($urandom_range(0, 1)), '0);
        idle(3);
        check_value("correction_count", 32'(correction_count), 0);

        for (int g = 0; g < N_EVENT_GROUPS; g++) begin
            inject_group(g % NUM_FLIP_PATTERNS, 1'b0);
        end
        for (int g = 0; g < N_TIE_GROUPS; g++) begin
            inject_group(g % NUM_FLIP_PATTERNS, 1'b1);
        end

        repeat (N_RANDOM) begin
            send_sample(1'($urandom_range(0, 1)), residual_t'($urandom_range(0, 255)));
            idle($urandom_range(0, MAX_GAP));
        end

        // mid-run reset, then refill
        idle(DRAIN_CYCLES);
        assert (exp_q.size() == 0) else begin
            protocol_errors++;
            $display("%0d results still pending before the mid-run reset", exp_q.size());
        end
        apply_reset(RESET_CYCLES);
        check_value("correction_count", 32'(correction_count), 0);
        send_sample(1'b1, residual_t'(-20));
        send_sample(1'b0, residual_t'(13));
        idle(4);  // any out_valid here has an empty queue
        send_sample(1'b1, residual_t'(40));
        idle(DRAIN_CYCLES);

        assert (exp_q.size() == 0) else begin
            protocol_errors++;
            $display("%0d expected results never came out", exp_q.size());
        end
        assert (n_outputs == n_windows) else begin
            protocol_errors++;
            $display("%0d windows completed but %0d outputs seen", n_windows, n_outputs);
        end
        report_counts(0);
        if (mismatch_errors == 0 && protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
src/detector_pkg.sv
src/residual_window.sv
src/fp_checker.sv
src/sliding_detector_single_slice.sv
src/bit_corrector.sv
src/sliding_detector_top.sv
bench/detector_tb.sv

// ==== src/bit_corrector.sv ====
`timescale 1ns/10ps
`default_nettype none

module bit_corrector
    import detector_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire window_t                  window,
    input  wire logic [FLAG_BITWIDTH-1:0] error_flag,
    input  wire energy_t                  mmse_val,
    output logic [SEQ_LENGTH-1:0]         corrected_bits,
    output logic                          out_valid,
    output decision_t                     decision,
    output logic [COUNT_BITWIDTH-1:0]     correction_count
);

    logic [FLIP_PATTERN_DEPTH-1:0] flip_mask;
    logic [FLAG_BITWIDTH-1:0]      dec_flag;
    energy_t                       dec_mmse;
    logic [SEQ_LENGTH-1:0]         dec_bits;

    // flag k selects pattern k-1
    always_comb begin
        flip_mask = '0;
        if (error_flag != '0) begin
            flip_mask = FLIP_PATTERNS[error_flag - FLAG_BITWIDTH'(1)];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid        <= 1'b0;
            correction_count <= '0;
        end else begin
            out_valid <= window.valid;
            if (window.valid && (error_flag != '0)) begin
                correction_count <= correction_count + 1'b1;  // wraps
            end
        end
    end

    always_ff @(posedge clk) begin
        if (window.valid) begin
            dec_flag       <= error_flag;
            dec_mmse       <= mmse_val;
            dec_bits       <= window.bits;
            corrected_bits <= window.bits ^ flip_mask;
        end
    end

    assign decision = '{
        valid:      out_valid,
        error_flag: dec_flag,
        mmse_val:   dec_mmse,
        bits:       dec_bits
    };

    // slice must never hand over a flag past the last pattern
    a_flag_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> decision.error_flag <= FLAG_BITWIDTH'(NUM_FLIP_PATTERNS)
    );

    a_no_flip_passthru: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && (decision.error_flag == '0) |-> corrected_bits == decision.bits
    );

endmodule

`default_nettype wire

// ==== src/detector_pkg.sv ====
`default_nettype none

package detector_pkg;

    // window and pattern geometry
    localparam int SEQ_LENGTH         = 3;
    localparam int FLIP_PATTERN_DEPTH = 3;
    localparam int NUM_FLIP_PATTERNS  = 4;
    localparam int CHANNEL_TAPS       = FLIP_PATTERN_DEPTH + SEQ_LENGTH - 1;

    // datapath widths
    localparam int EST_ERROR_BITWIDTH   = 8;
    localparam int EST_CHANNEL_BITWIDTH = 8;
    localparam int ENER_BITWIDTH        = 18;
    localparam int FLAG_BITWIDTH        = 3;  // 0 = no flip, k = pattern k-1
    localparam int COUNT_BITWIDTH       = 16;
    localparam int FILL_BITWIDTH        = $clog2(SEQ_LENGTH + 1);

    localparam int RAW_SQR_BITWIDTH = 2 * EST_ERROR_BITWIDTH;
    localparam int ADJ_BITWIDTH     = 12;  // residual plus three 2*tap terms
    localparam int SQR_BITWIDTH     = 2 * ADJ_BITWIDTH;
    localparam int SUM_BITWIDTH     = SQR_BITWIDTH + 2;

    localparam logic [ENER_BITWIDTH-1:0] ENER_MAX = '1;

    // bit j of an entry marks window position j
    localparam logic [NUM_FLIP_PATTERNS-1:0][FLIP_PATTERN_DEPTH-1:0] FLIP_PATTERNS = {
        3'b101,  // entry 3
        3'b111,
        3'b011,
        3'b010   // entry 0
    };

    typedef logic signed [EST_ERROR_BITWIDTH-1:0]   residual_t;
    typedef logic signed [EST_CHANNEL_BITWIDTH-1:0] tap_t;
    typedef logic [ENER_BITWIDTH-1:0]               energy_t;

    typedef tap_t [CHANNEL_TAPS-1:0] channel_t;

    typedef struct packed {
        logic                       valid;
        logic [SEQ_LENGTH-1:0]      bits;       // position 0 is the oldest
        residual_t [SEQ_LENGTH-1:0] residuals;
    } window_t;

    typedef struct packed {
        logic                     valid;
        logic [FLAG_BITWIDTH-1:0] error_flag;
        energy_t                  mmse_val;
        logic [SEQ_LENGTH-1:0]    bits;         // before correction
    } decision_t;

endpackage

`default_nettype wire

// ==== src/fp_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_checker
    import detector_pkg::*;
#(
    parameter int pattern_index = 0
) (
    input  wire residual_t [SEQ_LENGTH-1:0] seq,
    input  wire logic [SEQ_LENGTH-1:0]      bits,
    input  wire channel_t                   channel,
    output energy_t                         mse_val
);

    localparam logic [FLIP_PATTERN_DEPTH-1:0] PATTERN = FLIP_PATTERNS[pattern_index];

    logic signed [2:0]              delta [FLIP_PATTERN_DEPTH];
    logic signed [ADJ_BITWIDTH-1:0] adj   [SEQ_LENGTH];
    logic [SQR_BITWIDTH-1:0]        sqr   [SEQ_LENGTH];
    logic [SUM_BITWIDTH-1:0]        ener_sum;

    // a set bit is symbol +1, so flipping it moves the symbol by -2
    always_comb begin
        for (int j = 0; j < FLIP_PATTERN_DEPTH; j++) begin
            if (!PATTERN[j]) begin
                delta[j] = 3'sd0;
            end else if (bits[j]) begin
                delta[j] = -3'sd2;
            end else begin
                delta[j] = 3'sd2;
            end
        end
    end

    // cancel the event through the channel
    always_comb begin
        for (int i = 0; i < SEQ_LENGTH; i++) begin
            adj[i] = ADJ_BITWIDTH'($signed(seq[i]));
            for (int j = 0; j < FLIP_PATTERN_DEPTH; j++) begin
                adj[i] = adj[i]
                       + delta[j] * $signed(channel[i - j + FLIP_PATTERN_DEPTH - 1]);
            end
        end
    end

    always_comb begin
        ener_sum = '0;
        for (int i = 0; i < SEQ_LENGTH; i++) begin
            sqr[i]   = SQR_BITWIDTH'(adj[i]) * SQR_BITWIDTH'(adj[i]);
            ener_sum = ener_sum + SUM_BITWIDTH'(sqr[i]);
        end
    end

    // clamp to the energy range
    assign mse_val = (ener_sum > SUM_BITWIDTH'(ENER_MAX)) ? ENER_MAX
                                                          : ener_sum[ENER_BITWIDTH-1:0];

endmodule

`default_nettype wire

// ==== src/residual_window.sv ====
`timescale 1ns/10ps
`default_nettype none

module residual_window
    import detector_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      sample_valid,
    input  wire logic      sample_bit,
    input  wire residual_t sample_residual,
    output window_t        window
);

    logic [FILL_BITWIDTH-1:0]   fill_cnt;
    logic                       win_valid;
    logic [SEQ_LENGTH-1:0]      win_bits;
    residual_t [SEQ_LENGTH-1:0] win_res;

    // fill counter and window strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= sample_valid && (fill_cnt >= FILL_BITWIDTH'(SEQ_LENGTH - 1));
            if (sample_valid && (fill_cnt != FILL_BITWIDTH'(SEQ_LENGTH))) begin
                fill_cnt <= fill_cnt + 1'b1;  // saturates at full
            end
        end
    end

    // newest sample enters at the top, oldest drops out of position 0
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            win_bits <= {sample_bit, win_bits[SEQ_LENGTH-1:1]};
            win_res  <= {sample_residual, win_res[SEQ_LENGTH-1:1]};
        end
    end

    assign window = '{valid: win_valid, bits: win_bits, residuals: win_res};

    a_valid_needs_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        win_valid |-> (fill_cnt == FILL_BITWIDTH'(SEQ_LENGTH)) && $past(sample_valid)
    );

endmodule

`default_nettype wire

// ==== src/sliding_detector_single_slice.sv ====
`timescale 1ns/10ps
`default_nettype none

module sliding_detector_single_slice
    import detector_pkg::*;
(
    input  wire residual_t [SEQ_LENGTH-1:0] residual_error_trace,
    input  wire logic [SEQ_LENGTH-1:0]      bits,
    input  wire channel_t                   channel,
    output logic [FLAG_BITWIDTH-1:0]        error_flag,
    output energy_t                         mmse_val
);

    energy_t                       ener_none;
    energy_t                       ener_pat [NUM_FLIP_PATTERNS];
    energy_t                       mse_val  [NUM_FLIP_PATTERNS+1];
    logic [RAW_SQR_BITWIDTH-1:0]   sqr_val;

    // unflipped energy
    always_comb begin
        ener_none = '0;
        sqr_val   = '0;
        for (int ii = 0; ii < SEQ_LENGTH; ii++) begin
            sqr_val   = RAW_SQR_BITWIDTH'($signed(residual_error_trace[ii]))
                      * RAW_SQR_BITWIDTH'($signed(residual_error_trace[ii]));
            ener_none = ener_none + ENER_BITWIDTH'(sqr_val);
        end
    end

    for (genvar gi = 0; gi < NUM_FLIP_PATTERNS; gi++) begin : g_fpc
        fp_checker #(
            .pattern_index(gi)
        ) fpc_i (
            .seq     (residual_error_trace),
            .bits    (bits),
            .channel (channel),
            .mse_val (ener_pat[gi])
        );
    end

    // strict-less scan, so ties stay with the lower index
    always_comb begin
        mse_val[0] = ener_none;
        for (int ii = 0; ii < NUM_FLIP_PATTERNS; ii++) begin
            mse_val[ii+1] = ener_pat[ii];
        end
        error_flag = '0;
        for (int ii = 1; ii < NUM_FLIP_PATTERNS + 1; ii++) begin
            if (mse_val[ii] < mse_val[error_flag]) begin
                error_flag = FLAG_BITWIDTH'(ii);
            end
        end
        mmse_val = mse_val[error_flag];
    end

endmodule

`default_nettype wire

// ==== src/sliding_detector_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sliding_detector_top
    import detector_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 sample_valid,
    input  wire logic                 sample_bit,
    input  wire residual_t            sample_residual,
    input  wire channel_t             channel,     // quasi-static
    output logic                      out_valid,
    output logic [SEQ_LENGTH-1:0]     corrected_bits,
    output logic [FLAG_BITWIDTH-1:0]  error_flag,
    output energy_t                   mmse_val,
    output logic [COUNT_BITWIDTH-1:0] correction_count
);

    window_t                  window;
    logic [FLAG_BITWIDTH-1:0] slice_flag;
    energy_t                  slice_mmse;
    decision_t                decision;

    residual_window u_window (
        .clk             (clk),
        .rst_n           (rst_n),
        .sample_valid    (sample_valid),
        .sample_bit      (sample_bit),
        .sample_residual (sample_residual),
        .window          (window)
    );

    sliding_detector_single_slice u_slice (
        .residual_error_trace (window.residuals),
        .bits                 (window.bits),
        .channel              (channel),
        .error_flag           (slice_flag),
        .mmse_val             (slice_mmse)
    );

    bit_corrector u_corrector (
        .clk              (clk),
        .rst_n            (rst_n),
        .window           (window),
        .error_flag       (slice_flag),
        .mmse_val         (slice_mmse),
        .corrected_bits   (corrected_bits),
        .out_valid        (out_valid),
        .decision         (decision),
        .correction_count (correction_count)
    );

    assign error_flag = decision.error_flag;
    assign mmse_val   = decision.mmse_val;

endmodule

`default_nettype wire
